/* verilog/dmem_settings.svh */
// Word width must be a multiple of 8 and wait states at least 1; bank depth must be a power of two
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// Core data word
`define DMEM_XLEN 32
// One byte-wide bank per lane
`define DMEM_LANES (`DMEM_XLEN / 8)
`define DMEM_OFS_W $clog2(`DMEM_LANES)

`define DMEM_DEPTH 256 // Words per bank
`define DMEM_IDX_W $clog2(`DMEM_DEPTH)

// Cycles from acceptance to bank ready
`define DMEM_WAIT_STATES 2

`endif

/* verilog/dmem_pkg.sv */
// Shared types of the data-memory path; all widths follow dmem_settings.svh
`default_nettype none

`include "dmem_settings.svh"

package dmem_pkg;

	// funct3 of RV32 loads and stores
	typedef enum logic [2:0] {
		MEM_B  = 3'b000,
		MEM_H  = 3'b001,
		MEM_W  = 3'b010,
		MEM_BU = 3'b100,
		MEM_HU = 3'b101
	} mem_width_e;

	// Access size once funct3 is decoded
	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_HALF = 2'd1,
		SZ_WORD = 2'd2
	} mem_size_e;

	typedef struct packed {
		logic                  write; // Store when set
		mem_width_e            width;
		logic [`DMEM_XLEN-1:0] addr;  // Byte address
		logic [`DMEM_XLEN-1:0] wdata;
	} lsu_req_t;

	typedef struct packed {
		logic                   en;
		logic                   we;
		logic [`DMEM_IDX_W-1:0] idx; // Word index inside the bank
		logic [7:0]             wbyte;
	} lane_req_t;

	typedef struct packed {
		logic       ready;
		logic [7:0] rbyte;
	} lane_rsp_t;

	// What the aligner needs of a load
	typedef struct packed {
		logic [`DMEM_OFS_W-1:0] offset;
		mem_size_e              size;
		logic                   uns; // Zero extend
	} load_ctx_t;

	typedef struct packed {
		logic ld_misaligned;
		logic st_misaligned;
	} exc_t;

endpackage

`default_nettype wire

/* verilog/lsu_request.sv */
// One access in flight; the core must hold i_req_valid and i_req unchanged while o_stall is high
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module lsu_request (
	input  wire                                   i_clk,
	input  wire                                   i_arst_n,
	input  wire                                   i_req_valid,
	input  wire dmem_pkg::lsu_req_t               i_req,
	input  wire                                   i_lane0_ready,
	output dmem_pkg::lane_req_t [`DMEM_LANES-1:0] o_lanes,
	output dmem_pkg::load_ctx_t                   o_ctx,
	output logic                                  o_ctx_load,
	output logic                                  o_stall,
	output dmem_pkg::exc_t                        o_exc
);

	localparam int LANES = `DMEM_LANES;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} state_e;

	state_e state;
	state_e next_state;

	dmem_pkg::mem_size_e    size;
	logic [`DMEM_OFS_W-1:0] offset;
	logic [`DMEM_IDX_W-1:0] word_idx;
	logic [LANES-1:0]       byte_en;
	logic [`DMEM_XLEN-1:0]  wdata_sh;
	logic                   misaligned;
	logic                   accept;

	assign offset   = i_req.addr[`DMEM_OFS_W-1:0];
	assign word_idx = i_req.addr[`DMEM_OFS_W +: `DMEM_IDX_W]; // Wraps modulo the bank depth

	always_comb begin
		case (i_req.width)
			dmem_pkg::MEM_B, dmem_pkg::MEM_BU: size = dmem_pkg::SZ_BYTE;
			dmem_pkg::MEM_H, dmem_pkg::MEM_HU: size = dmem_pkg::SZ_HALF;
			default:                           size = dmem_pkg::SZ_WORD; // Unused codes act as LW
		endcase
	end

	// Lanes touched by the access
	always_comb begin
		case (size)
			dmem_pkg::SZ_BYTE: byte_en = LANES'(1) << offset;
			dmem_pkg::SZ_HALF: byte_en = LANES'(3) << {offset[`DMEM_OFS_W-1:1], 1'b0};
			default:           byte_en = '1;
		endcase
	end

	assign misaligned = ((size == dmem_pkg::SZ_HALF) && offset[0]) ||
		((size == dmem_pkg::SZ_WORD) && (|offset));

	assign o_exc.ld_misaligned = i_req_valid && !i_req.write && misaligned;
	assign o_exc.st_misaligned = i_req_valid && i_req.write && misaligned;

	assign accept = i_req_valid && (state == IDLE) && !misaligned;

	// Store bytes moved onto their lanes
	assign wdata_sh = i_req.wdata << {offset, 3'b000};

	// Every bank runs the access so lane 0 always reports completion
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			o_lanes[i].en    = accept;
			o_lanes[i].we    = accept && i_req.write && byte_en[i];
			o_lanes[i].idx   = word_idx;
			o_lanes[i].wbyte = wdata_sh[8*i +: 8];
		end
	end

	assign o_ctx.offset = offset;
	assign o_ctx.size   = size;
	assign o_ctx.uns    = (i_req.width == dmem_pkg::MEM_BU) || (i_req.width == dmem_pkg::MEM_HU);
	assign o_ctx_load   = accept && !i_req.write;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (accept && i_req.write) begin
					next_state = WRITE;
				end else if (accept) begin
					next_state = READ;
				end
			end
			READ, WRITE: begin
				if (i_lane0_ready) begin
					next_state = IDLE; // Core moves on at the end of this cycle
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// Busy or requesting, released by ready or an exception
	assign o_stall = ((state != IDLE) || i_req_valid) && !i_lane0_ready && !(|o_exc);

endmodule

`default_nettype wire

/* verilog/dmem_bank.sv */
// Takes a new command only after the previous one has answered; read data holds until the next read
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module dmem_bank (
	input  wire                      i_clk,
	input  wire                      i_arst_n,
	input  wire dmem_pkg::lane_req_t i_lane,
	output dmem_pkg::lane_rsp_t      o_rsp
);

	localparam int WAIT  = `DMEM_WAIT_STATES;
	localparam int CNT_W = (WAIT > 1) ? $clog2(WAIT) : 1;

	logic [7:0]          mem [`DMEM_DEPTH];
	dmem_pkg::lane_req_t cmd_q;
	dmem_pkg::lane_req_t cmd;
	logic [CNT_W-1:0]    cnt;     // Wait states left
	logic                fire;    // Access happens at this edge
	logic                ready_q;
	logic [7:0]          rbyte_q;

	// With a single wait state the access is done on the accepting edge
	assign cmd  = (WAIT == 1) ? i_lane : cmd_q;
	assign fire = (WAIT == 1) ? i_lane.en : (cnt == CNT_W'(1));

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt     <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= fire; // One-cycle pulse
			if (i_lane.en) begin
				cnt <= CNT_W'(WAIT - 1);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_lane.en) begin
			cmd_q <= i_lane;
		end
	end

	always_ff @(posedge i_clk) begin
		if (fire) begin
			if (cmd.we) begin
				mem[cmd.idx] <= cmd.wbyte;
			end else begin
				rbyte_q <= mem[cmd.idx];
			end
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rbyte = rbyte_q;

endmodule

`default_nettype wire

/* verilog/lsu_load_align.sv */
// Keeps the context of one load; a ready with no load pending is a store and is dropped
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module lsu_load_align (
	input  wire                                       i_clk,
	input  wire                                       i_arst_n,
	input  wire dmem_pkg::load_ctx_t                  i_ctx,
	input  wire                                       i_ctx_load,
	input  wire dmem_pkg::lane_rsp_t [`DMEM_LANES-1:0] i_rsp,
	output logic                                      o_load_valid,
	output logic [`DMEM_XLEN-1:0]                     o_load_data
);

	localparam int XLEN = `DMEM_XLEN;

	dmem_pkg::load_ctx_t ctx_q;
	logic                pending; // Load in flight
	logic [XLEN-1:0]     merged;
	logic [XLEN-1:0]     shifted;
	logic [XLEN-1:0]     result;
	logic                sign;
	logic                done;

	always_comb begin
		for (int i = 0; i < `DMEM_LANES; i++) begin
			merged[8*i +: 8] = i_rsp[i].rbyte;
		end
	end

	// Addressed byte or half down to bit 0
	assign shifted = merged >> {ctx_q.offset, 3'b000};

	always_comb begin
		sign   = 1'b0;
		result = shifted;
		case (ctx_q.size)
			dmem_pkg::SZ_BYTE: begin
				sign   = !ctx_q.uns && shifted[7];
				result = {{(XLEN-8){sign}}, shifted[7:0]};
			end
			dmem_pkg::SZ_HALF: begin
				sign   = !ctx_q.uns && shifted[15];
				result = {{(XLEN-16){sign}}, shifted[15:0]};
			end
			default: result = shifted;
		endcase
	end

	assign done = pending && i_rsp[0].ready; // All lanes answer together

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pending      <= 1'b0;
			o_load_valid <= 1'b0;
		end else begin
			o_load_valid <= done;
			if (i_ctx_load) begin
				pending <= 1'b1;
			end else if (i_rsp[0].ready) begin
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_ctx_load) begin
			ctx_q <= i_ctx;
		end
		if (done) begin
			o_load_data <= result;
		end
	end

endmodule

`default_nettype wire

/* verilog/dmem_subsys.sv */
// Data-memory side of an RV32 core; one access at a time with latency set by DMEM_WAIT_STATES
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module dmem_subsys (
	input  wire                     i_clk,
	input  wire                     i_arst_n,
	input  wire                     i_req_valid,
	input  wire dmem_pkg::lsu_req_t i_req,
	output logic                    o_stall,
	output dmem_pkg::exc_t          o_exc,
	output logic                    o_load_valid,
	output logic [`DMEM_XLEN-1:0]   o_load_data
);

	dmem_pkg::lane_req_t [`DMEM_LANES-1:0] lanes;
	dmem_pkg::lane_rsp_t [`DMEM_LANES-1:0] rsps;
	dmem_pkg::load_ctx_t                   ctx;
	logic                                  ctx_load;

	lsu_request u_request (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_req_valid  (i_req_valid),
		.i_req        (i_req),
		.i_lane0_ready(rsps[0].ready),
		.o_lanes      (lanes),
		.o_ctx        (ctx),
		.o_ctx_load   (ctx_load),
		.o_stall      (o_stall),
		.o_exc        (o_exc)
	);

	// One bank per byte lane
	for (genvar g = 0; g < `DMEM_LANES; g++) begin : g_bank
		dmem_bank u_bank (
			.i_clk   (i_clk),
			.i_arst_n(i_arst_n),
			.i_lane  (lanes[g]),
			.o_rsp   (rsps[g])
		);
	end

	lsu_load_align u_align (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_ctx       (ctx),
		.i_ctx_load  (ctx_load),
		.i_rsp       (rsps),
		.o_load_valid(o_load_valid),
		.o_load_data (o_load_data)
	);

endmodule

`default_nettype wire

/* testbench/dmem_subsys_chk.sv */
// Watches only the top-level ports; the stall bound follows DMEM_WAIT_STATES
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module dmem_subsys_chk (
	input wire                 i_clk,
	input wire                 i_arst_n,
	input wire                 i_stall,
	input wire dmem_pkg::exc_t i_exc,
	input wire                 i_load_valid
);

	logic [7:0] stall_run; // Stall cycles seen before this one

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			stall_run <= '0;
		end else if (!i_stall) begin
			stall_run <= '0;
		end else if (stall_run != '1) begin
			stall_run <= stall_run + 1'b1; // Saturates
		end
	end

	a_stall_exc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_stall && (|i_exc)))
		else $error("stall raised together with an exception");

	a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_load_valid |=> !i_load_valid)
		else $error("load valid held for two cycles");

	// Released in the ready cycle at the latest
	a_stall_bound: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_stall && (stall_run >= 8'(`DMEM_WAIT_STATES))))
		else $error("stall held longer than the wait states");

endmodule

bind dmem_subsys dmem_subsys_chk u_chk (
	.i_clk       (i_clk),
	.i_arst_n    (i_arst_n),
	.i_stall     (o_stall),
	.i_exc       (o_exc),
	.i_load_valid(o_load_valid)
);

`default_nettype wire

/* testbench/dmem_subsys_tb.sv */
// Assumes a 32-bit word; stops at the first mismatch and bounds every wait by TIMEOUT cycles
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module dmem_subsys_tb;

	localparam int ABITS   = `DMEM_OFS_W + `DMEM_IDX_W; // Byte address bits that reach memory
	localparam int TIMEOUT = 20;

	logic                  clk;
	logic                  arst_n;
	logic                  req_valid;
	dmem_pkg::lsu_req_t    req;
	logic                  stall;
	dmem_pkg::exc_t        exc;
	logic                  load_valid;
	logic [`DMEM_XLEN-1:0] load_data;

	logic [7:0]  shadow [1 << ABITS]; // Byte image of the banks
	logic [31:0] exp_q [$];           // Expected load words in order
	integer      seed;

	dmem_subsys uut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_req_valid (req_valid),
		.i_req       (req),
		.o_stall     (stall),
		.o_exc       (exc),
		.o_load_valid(load_valid),
		.o_load_data (load_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, got));
		end
	endtask

	task automatic check_exc(input string name, input dmem_pkg::exc_t got,
			input dmem_pkg::exc_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t ns: %s expected %b, got %b", $time, name, exp, got));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t ns: %s expected %b, got %b", $time, name, exp, got));
		end
	endtask

	function automatic logic misaligned(input logic [31:0] addr, input dmem_pkg::mem_width_e w);
		case (w)
			dmem_pkg::MEM_H, dmem_pkg::MEM_HU: return addr[0];
			dmem_pkg::MEM_W:                   return addr[1:0] != 2'b00;
			default:                           return 1'b0;
		endcase
	endfunction

	// Little-endian read of the shadow with RV32 extension rules
	function automatic logic [31:0] expect_load(input logic [31:0] addr,
			input dmem_pkg::mem_width_e w);
		logic [ABITS-1:0] a;
		logic [7:0]       b0;
		logic [7:0]       b1;
		a  = addr[ABITS-1:0]; // Upper bits wrap
		b0 = shadow[a];
		b1 = shadow[a + ABITS'(1)];
		case (w)
			dmem_pkg::MEM_B:  return {{24{b0[7]}}, b0};
			dmem_pkg::MEM_BU: return {24'h0, b0};
			dmem_pkg::MEM_H:  return {{16{b1[7]}}, b1, b0};
			dmem_pkg::MEM_HU: return {16'h0, b1, b0};
			default:          return {shadow[a + ABITS'(3)], shadow[a + ABITS'(2)], b1, b0};
		endcase
	endfunction

	task automatic shadow_store(input logic [31:0] addr, input dmem_pkg::mem_width_e w,
			input logic [31:0] wdata);
		logic [ABITS-1:0] a;
		a = addr[ABITS-1:0];
		shadow[a] = wdata[7:0];
		if (w != dmem_pkg::MEM_B && w != dmem_pkg::MEM_BU) begin
			shadow[a + ABITS'(1)] = wdata[15:8];
		end
		if (w == dmem_pkg::MEM_W) begin
			shadow[a + ABITS'(2)] = wdata[23:16];
			shadow[a + ABITS'(3)] = wdata[31:24];
		end
	endtask

	function automatic dmem_pkg::mem_width_e pick_width(input logic [31:0] r);
		case (r % 32'd5)
			32'd0:   return dmem_pkg::MEM_B;
			32'd1:   return dmem_pkg::MEM_H;
			32'd2:   return dmem_pkg::MEM_W;
			32'd3:   return dmem_pkg::MEM_BU;
			default: return dmem_pkg::MEM_HU;
		endcase
	endfunction

	// Called 1 ns after a rising edge; returns at the same point of a later cycle
	task automatic do_access(input logic wr, input dmem_pkg::mem_width_e w,
			input logic [31:0] addr, input logic [31:0] wdata, input logic wait_load);
		dmem_pkg::exc_t exp_exc;
		logic           bad;
		int             n;
		bad                   = misaligned(addr, w);
		exp_exc.ld_misaligned = bad && !wr;
		exp_exc.st_misaligned = bad && wr;
		req_valid = 1'b1;
		req.write = wr;
		req.width = w;
		req.addr  = addr;
		req.wdata = wdata;
		if (!bad && !wr) begin
			exp_q.push_back(expect_load(addr, w));
		end
		@(negedge clk);
		check_exc("o_exc", exc, exp_exc);
		check_flag("o_stall", stall, !bad);
		n = 0;
		while (stall) begin
			n++;
			if (n > TIMEOUT) abort_run("o_stall stayed high past the timeout");
			@(negedge clk);
		end
		if (!bad) check_word("stall cycles", 32'(n), 32'(`DMEM_WAIT_STATES));
		if (!bad && wr) shadow_store(addr, w, wdata);
		@(posedge clk);
		#1;
		req_valid = 1'b0; // Core has moved on
		if (!bad && !wr && wait_load) begin
			n = 0;
			@(negedge clk);
			while (!load_valid) begin
				n++;
				if (n > TIMEOUT) abort_run("o_load_valid never rose after a load");
				@(negedge clk);
			end
			check_word("load valid delay", 32'(n), 32'd0); // Right after the ready cycle
			@(posedge clk);
			#1;
		end
	endtask

	// Load results checked where the registered outputs are stable
	always @(negedge clk) begin
		if (load_valid) begin
			if (exp_q.size() == 0) abort_run("o_load_valid rose with no load pending");
			else check_word("o_load_data", load_data, exp_q.pop_front());
		end
	end

	initial begin
		logic [31:0]          r;
		logic [31:0]          addr;
		logic [31:0]          base;
		dmem_pkg::mem_width_e w;
		int                   n;
		seed      = 32'ha6b28e14;
		arst_n    = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		check_flag("o_stall", stall, 1'b0);
		check_flag("o_load_valid", load_valid, 1'b0);
		check_exc("o_exc", exc, '0);
		@(posedge clk);
		#1;

		// Whole memory gets a known image first
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			do_access(1'b1, dmem_pkg::MEM_W, 32'(i) << 2, 32'(i) * 32'h9e37_79b1, 1'b1);
		end
		r = $random(seed);
		do_access(1'b1, dmem_pkg::MEM_W, 32'h0000_0040, r, 1'b1);
		do_access(1'b0, dmem_pkg::MEM_W, 32'h0000_0040, 32'd0, 1'b1);

		base = 32'h0000_0100;
		for (int off = 0; off < 4; off++) begin
			r = $random(seed);
			do_access(1'b1, dmem_pkg::MEM_B, base + 32'(off), r, 1'b1);
			do_access(1'b0, dmem_pkg::MEM_W, base, 32'd0, 1'b1);
		end
		for (int off = 0; off < 4; off += 2) begin
			r = $random(seed);
			do_access(1'b1, dmem_pkg::MEM_H, base + 32'(off), r, 1'b1);
			do_access(1'b0, dmem_pkg::MEM_W, base, 32'd0, 1'b1);
		end

		// Mixed sign bits in bytes and halves
		do_access(1'b1, dmem_pkg::MEM_W, base, 32'h6a81_f07c, 1'b1);
		for (int off = 0; off < 4; off++) begin
			do_access(1'b0, dmem_pkg::MEM_B, base + 32'(off), 32'd0, 1'b1);
			do_access(1'b0, dmem_pkg::MEM_BU, base + 32'(off), 32'd0, 1'b1);
			if (off % 2 == 0) begin
				do_access(1'b0, dmem_pkg::MEM_H, base + 32'(off), 32'd0, 1'b1);
				do_access(1'b0, dmem_pkg::MEM_HU, base + 32'(off), 32'd0, 1'b1);
			end
		end

		base = 32'h0000_0200;
		do_access(1'b1, dmem_pkg::MEM_W, base, 32'h0f1e_2d3c, 1'b1);
		for (int off = 1; off < 4; off++) begin
			do_access(1'b0, dmem_pkg::MEM_W, base + 32'(off), 32'd0, 1'b1);
			do_access(1'b1, dmem_pkg::MEM_W, base + 32'(off), 32'hffff_ffff, 1'b1);
			if (off % 2 == 1) begin
				do_access(1'b0, dmem_pkg::MEM_H, base + 32'(off), 32'd0, 1'b1);
				do_access(1'b0, dmem_pkg::MEM_HU, base + 32'(off), 32'd0, 1'b1);
				do_access(1'b1, dmem_pkg::MEM_H, base + 32'(off), 32'hffff_ffff, 1'b1);
			end
		end
		do_access(1'b0, dmem_pkg::MEM_W, base, 32'd0, 1'b1); // Still the old word

		for (int k = 0; k < 300; k++) begin
			r    = $random(seed);
			w    = pick_width(r);
			addr = $random(seed);
			if (r[29]) addr[1:0] = 2'b00;
			do_access(r[31], w, addr, $random(seed), r[30]);
		end

		n = 0;
		while (exp_q.size() != 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run($sformatf("%0d load results never arrived", exp_q.size()));
		end
	end

endmodule

`default_nettype wire

/* dmem_subsys.f */
+incdir+verilog
verilog/dmem_pkg.sv
verilog/lsu_request.sv
verilog/dmem_bank.sv
verilog/lsu_load_align.sv
verilog/dmem_subsys.sv
testbench/dmem_subsys_chk.sv
testbench/dmem_subsys_tb.sv

/* Makefile */
TOP := dmem_subsys_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f dmem_subsys.f --top-module $(TOP) -Mdir obj_dir

# Passes only when the simulation prints the pass message
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

lint:
	verilator --lint-only --timing -f dmem_subsys.f --top-module $(TOP)

clean:
	rm -rf obj_dir
